//--- verilog/gemm_defines.svh
// ----------------------------------------------------------------------
// gemm accelerator sizing macros
// matrix dimension, element and accumulator widths, memory address width
// ----------------------------------------------------------------------
`ifndef GEMM_DEFINES_SVH
`define GEMM_DEFINES_SVH

// square tile, rows and columns
`define GEMM_DIM 4

// signed matrix element
`define GEMM_EW 8

// signed result word
`define GEMM_ACC_W 32

// byte address on the memory ports
`define GEMM_AW 32

`endif

//--- verilog/gemm_pkg.sv
// ----------------------------------------------------------------------
// gemm accelerator shared types
// element, row and tile shapes, configuration and write beat structs
// ----------------------------------------------------------------------
`include "gemm_defines.svh"

package gemm_pkg;

    // one signed matrix element
    typedef logic signed [`GEMM_EW-1:0] elem_t;

    // one memory word, element k in bits 8k+7..8k
    typedef elem_t [`GEMM_DIM-1:0] row_t;

    // accumulator and result shapes
    typedef logic signed [`GEMM_ACC_W-1:0] acc_t;
    typedef acc_t [`GEMM_DIM-1:0] acc_row_t;
    typedef acc_row_t [`GEMM_DIM-1:0] acc_tile_t;

    // base addresses latched at start
    typedef struct packed {
        logic [`GEMM_AW-1:0] a_addr;
        logic [`GEMM_AW-1:0] b_addr;
        logic [`GEMM_AW-1:0] c_addr;
    } mat_cfg_t;

    // single write beat, address and data together
    typedef struct packed {
        logic [`GEMM_AW-1:0]    addr;
        logic [`GEMM_ACC_W-1:0] data;
    } mem_wr_t;

    // row index into a tile buffer
    typedef logic [$clog2(`GEMM_DIM)-1:0] buf_addr_t;

endpackage

//--- verilog/tile_buffer.sv
// ----------------------------------------------------------------------
// tile buffer
// four row registers, one write port, one registered read port
// ----------------------------------------------------------------------
`timescale 1ns/100ps
`include "gemm_defines.svh"

module tile_buffer (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                wr_en_i,
    input  gemm_pkg::buf_addr_t wr_addr_i,
    input  gemm_pkg::row_t      wr_data_i,
    input  gemm_pkg::buf_addr_t rd_addr_i,
    output gemm_pkg::row_t      rd_data_o
);
    import gemm_pkg::*;

    // row storage
    row_t mem_q [`GEMM_DIM];

    // whole rows only, no byte enables
    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem_q[wr_addr_i] <= wr_data_i;
        end
    end

    // read data lands one cycle after the address
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_data_o <= '0;
        end else begin
            rd_data_o <= mem_q[rd_addr_i];
        end
    end

endmodule

//--- verilog/dma_fetch.sv
// ----------------------------------------------------------------------
// fetch DMA
// issues the eight row reads of A and B back to back and steers the
// in-order responses into the two tile buffers
// ----------------------------------------------------------------------
`timescale 1ns/100ps
`include "gemm_defines.svh"

module dma_fetch (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  start_i,
    input  gemm_pkg::mat_cfg_t    cfg_i,
    output gemm_pkg::mat_cfg_t    cfg_o,
    output logic                  rd_req_valid_o,
    output logic [`GEMM_AW-1:0]   rd_req_addr_o,
    input  logic                  rd_req_ready_i,
    input  logic                  rd_rsp_valid_i,
    input  gemm_pkg::row_t        rd_rsp_data_i,
    output logic                  buf_a_wr_en_o,
    output logic                  buf_b_wr_en_o,
    output gemm_pkg::buf_addr_t   buf_wr_addr_o,
    output gemm_pkg::row_t        buf_wr_data_o,
    output logic                  fetch_done_o
);
    import gemm_pkg::*;

    // counter layout: row index, then matrix select (0 = A, 1 = B)
    localparam int ROW_W = $clog2(`GEMM_DIM);
    localparam int CNT_W = ROW_W + 2;
    localparam logic [CNT_W-1:0] LAST_IDX = CNT_W'(2 * `GEMM_DIM - 1);

    mat_cfg_t            cfg_q;
    logic                busy_q;
    logic [CNT_W-1:0]    req_cnt_q;
    logic [CNT_W-1:0]    rsp_cnt_q;
    logic                req_fire;
    logic                rsp_fire;
    logic [`GEMM_AW-1:0] req_base;
    logic [`GEMM_AW-1:0] row_off;

    // addresses held for the whole run
    always_ff @(posedge clk) begin
        if (start_i) begin
            cfg_q <= cfg_i;
        end
    end

    assign cfg_o = cfg_q;

    assign req_fire = rd_req_valid_o && rd_req_ready_i;
    // late or stray responses outside a run are dropped
    assign rsp_fire = rd_rsp_valid_i && busy_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q         <= 1'b0;
            rd_req_valid_o <= 1'b0;
            req_cnt_q      <= '0;
            rsp_cnt_q      <= '0;
            fetch_done_o   <= 1'b0;
        end else begin
            fetch_done_o <= 1'b0;
            if (start_i) begin
                busy_q         <= 1'b1;
                rd_req_valid_o <= 1'b1;
                req_cnt_q      <= '0;
                rsp_cnt_q      <= '0;
            end else begin
                // request side, no wait on responses
                if (req_fire) begin
                    req_cnt_q <= req_cnt_q + 1'b1;
                    if (req_cnt_q == LAST_IDX) begin
                        rd_req_valid_o <= 1'b0;
                    end
                end
                // response side, eighth row ends the fetch
                if (rsp_fire) begin
                    rsp_cnt_q <= rsp_cnt_q + 1'b1;
                    if (rsp_cnt_q == LAST_IDX) begin
                        busy_q       <= 1'b0;
                        fetch_done_o <= 1'b1;
                    end
                end
            end
        end
    end

    // A rows first, then B rows, one word per row
    assign req_base      = req_cnt_q[ROW_W] ? cfg_q.b_addr : cfg_q.a_addr;
    assign row_off       = {{(`GEMM_AW - ROW_W - 2){1'b0}}, req_cnt_q[ROW_W-1:0], 2'b00};
    assign rd_req_addr_o = req_base + row_off;

    // responses come back in order, so the response count picks the buffer
    assign buf_a_wr_en_o = rsp_fire && !rsp_cnt_q[ROW_W];
    assign buf_b_wr_en_o = rsp_fire && rsp_cnt_q[ROW_W];
    assign buf_wr_addr_o = rsp_cnt_q[ROW_W-1:0];
    assign buf_wr_data_o = rd_rsp_data_i;

    // memory never answers a read that was not yet accepted
    a_rsp_after_req: assert property (@(posedge clk) disable iff (!rst_n)
        rd_rsp_valid_i |-> busy_q && (rsp_cnt_q < req_cnt_q));

    // new run only once the previous fetch has drained
    a_start_idle: assert property (@(posedge clk) disable iff (!rst_n)
        start_i |-> !busy_q);

endmodule

//--- verilog/mm_engine.sv
// ----------------------------------------------------------------------
// multiply engine
// steps (i, k) over sixteen cycles, adding A[i][k] * B row k into
// result row i with four parallel signed MACs
// ----------------------------------------------------------------------
`timescale 1ns/100ps
`include "gemm_defines.svh"

module mm_engine (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 start_i,
    output gemm_pkg::buf_addr_t  buf_a_rd_addr_o,
    output gemm_pkg::buf_addr_t  buf_b_rd_addr_o,
    input  gemm_pkg::row_t       buf_a_rd_data_i,
    input  gemm_pkg::row_t       buf_b_rd_data_i,
    output gemm_pkg::acc_tile_t  tile_o,
    output logic                 done_o
);
    import gemm_pkg::*;

    localparam buf_addr_t LAST = buf_addr_t'(`GEMM_DIM - 1);

    logic      stepping_q;
    buf_addr_t i_q;
    buf_addr_t k_q;
    // step indices delayed by the buffer read latency
    logic      mac_vld_q;
    buf_addr_t mac_i_q;
    buf_addr_t mac_k_q;
    elem_t     a_elem;
    acc_row_t  prod_row;
    acc_tile_t tile_q;

    // step sequencer, k inner, i outer
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stepping_q <= 1'b0;
            i_q        <= '0;
            k_q        <= '0;
            mac_vld_q  <= 1'b0;
            mac_i_q    <= '0;
            mac_k_q    <= '0;
            done_o     <= 1'b0;
        end else begin
            mac_vld_q <= stepping_q;
            mac_i_q   <= i_q;
            mac_k_q   <= k_q;
            // raised one cycle after the final accumulate
            done_o    <= mac_vld_q && (mac_i_q == LAST) && (mac_k_q == LAST);
            if (start_i) begin
                stepping_q <= 1'b1;
                i_q        <= '0;
                k_q        <= '0;
            end else if (stepping_q) begin
                if (k_q == LAST) begin
                    k_q <= '0;
                    if (i_q == LAST) begin
                        stepping_q <= 1'b0;
                    end else begin
                        i_q <= i_q + 1'b1;
                    end
                end else begin
                    k_q <= k_q + 1'b1;
                end
            end
        end
    end

    // A row i and B row k
    assign buf_a_rd_addr_o = i_q;
    assign buf_b_rd_addr_o = k_q;

    // A[i][k] times each element of B row k, sign extended to 32 bits
    always_comb begin
        a_elem = buf_a_rd_data_i[mac_k_q];
        for (int j = 0; j < `GEMM_DIM; j++) begin
            prod_row[j] = acc_t'(a_elem) * acc_t'(elem_t'(buf_b_rd_data_i[j]));
        end
    end

    // result tile, cleared on start, held after done
    always_ff @(posedge clk) begin
        if (start_i) begin
            tile_q <= '0;
        end else if (mac_vld_q) begin
            for (int j = 0; j < `GEMM_DIM; j++) begin
                tile_q[mac_i_q][j] <= tile_q[mac_i_q][j] + prod_row[j];
            end
        end
    end

    assign tile_o = tile_q;

    a_start_idle: assert property (@(posedge clk) disable iff (!rst_n)
        start_i |-> !stepping_q && !mac_vld_q);

    // fixed latency, never stalls
    a_done_latency: assert property (@(posedge clk) disable iff (!rst_n)
        start_i |-> ##18 done_o);

endmodule

//--- verilog/dma_writeback.sv
// ----------------------------------------------------------------------
// writeback DMA
// streams the sixteen result words to memory in row-major order and
// pulses done once the last beat is accepted
// ----------------------------------------------------------------------
`timescale 1ns/100ps
`include "gemm_defines.svh"

module dma_writeback (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 start_i,
    input  logic [`GEMM_AW-1:0]  c_addr_i,
    input  gemm_pkg::acc_tile_t  tile_i,
    output logic                 wr_valid_o,
    output gemm_pkg::mem_wr_t    wr_o,
    input  logic                 wr_ready_i,
    output logic                 done_o
);
    import gemm_pkg::*;

    localparam int ROW_W  = $clog2(`GEMM_DIM);
    localparam int BEAT_W = 2 * ROW_W;
    localparam logic [BEAT_W-1:0] LAST_BEAT = BEAT_W'(`GEMM_DIM * `GEMM_DIM - 1);

    logic [BEAT_W-1:0]   beat_q;
    logic                wr_fire;
    buf_addr_t           row_sel;
    buf_addr_t           col_sel;
    logic [`GEMM_AW-1:0] beat_off;

    assign wr_fire = wr_valid_o && wr_ready_i;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_valid_o <= 1'b0;
            beat_q     <= '0;
            done_o     <= 1'b0;
        end else begin
            done_o <= 1'b0;
            if (start_i) begin
                wr_valid_o <= 1'b1;
                beat_q     <= '0;
            end else if (wr_fire) begin
                if (beat_q == LAST_BEAT) begin
                    wr_valid_o <= 1'b0;
                    done_o     <= 1'b1;
                end else begin
                    beat_q <= beat_q + 1'b1;
                end
            end
        end
    end

    // beat n = 4i + j carries C[i][j]
    assign row_sel  = beat_q[BEAT_W-1 -: ROW_W];
    assign col_sel  = beat_q[ROW_W-1:0];
    assign beat_off = {{(`GEMM_AW - BEAT_W - 2){1'b0}}, beat_q, 2'b00};

    // counter and tile both hold under back-pressure
    assign wr_o.addr = c_addr_i + beat_off;
    assign wr_o.data = tile_i[row_sel][col_sel];

    a_beat_hold: assert property (@(posedge clk) disable iff (!rst_n)
        wr_valid_o && !wr_ready_i |=> wr_valid_o && $stable(wr_o));

endmodule

//--- verilog/gemm_accel_top.sv
// ----------------------------------------------------------------------
// gemm accelerator top
// fetch, two tile buffers, multiply engine and writeback in a chain
// ----------------------------------------------------------------------
`timescale 1ns/100ps
`include "gemm_defines.svh"

module gemm_accel_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 start_i,
    input  gemm_pkg::mat_cfg_t   cfg_i,
    output logic                 rd_req_valid_o,
    output logic [`GEMM_AW-1:0]  rd_req_addr_o,
    input  logic                 rd_req_ready_i,
    input  logic                 rd_rsp_valid_i,
    input  gemm_pkg::row_t       rd_rsp_data_i,
    output logic                 wr_valid_o,
    output gemm_pkg::mem_wr_t    wr_o,
    input  logic                 wr_ready_i,
    output logic                 done_o
);
    import gemm_pkg::*;

    // captured configuration
    mat_cfg_t  cfg;
    // buffer write side, shared address and data
    logic      buf_a_wr_en;
    logic      buf_b_wr_en;
    buf_addr_t buf_wr_addr;
    row_t      buf_wr_data;
    // buffer read side
    buf_addr_t buf_a_rd_addr;
    buf_addr_t buf_b_rd_addr;
    row_t      buf_a_rd_data;
    row_t      buf_b_rd_data;
    // stage handoff
    logic      fetch_done;
    logic      mm_done;
    acc_tile_t tile;

    dma_fetch u_fetch (
        .clk            (clk),
        .rst_n          (rst_n),
        .start_i        (start_i),
        .cfg_i          (cfg_i),
        .cfg_o          (cfg),
        .rd_req_valid_o (rd_req_valid_o),
        .rd_req_addr_o  (rd_req_addr_o),
        .rd_req_ready_i (rd_req_ready_i),
        .rd_rsp_valid_i (rd_rsp_valid_i),
        .rd_rsp_data_i  (rd_rsp_data_i),
        .buf_a_wr_en_o  (buf_a_wr_en),
        .buf_b_wr_en_o  (buf_b_wr_en),
        .buf_wr_addr_o  (buf_wr_addr),
        .buf_wr_data_o  (buf_wr_data),
        .fetch_done_o   (fetch_done)
    );

    tile_buffer buf_a (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr_en_i   (buf_a_wr_en),
        .wr_addr_i (buf_wr_addr),
        .wr_data_i (buf_wr_data),
        .rd_addr_i (buf_a_rd_addr),
        .rd_data_o (buf_a_rd_data)
    );

    tile_buffer buf_b (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr_en_i   (buf_b_wr_en),
        .wr_addr_i (buf_wr_addr),
        .wr_data_i (buf_wr_data),
        .rd_addr_i (buf_b_rd_addr),
        .rd_data_o (buf_b_rd_data)
    );

    // multiply starts when the last row has landed
    mm_engine u_mm (
        .clk             (clk),
        .rst_n           (rst_n),
        .start_i         (fetch_done),
        .buf_a_rd_addr_o (buf_a_rd_addr),
        .buf_b_rd_addr_o (buf_b_rd_addr),
        .buf_a_rd_data_i (buf_a_rd_data),
        .buf_b_rd_data_i (buf_b_rd_data),
        .tile_o          (tile),
        .done_o          (mm_done)
    );

    dma_writeback u_wb (
        .clk        (clk),
        .rst_n      (rst_n),
        .start_i    (mm_done),
        .c_addr_i   (cfg.c_addr),
        .tile_i     (tile),
        .wr_valid_o (wr_valid_o),
        .wr_o       (wr_o),
        .wr_ready_i (wr_ready_i),
        .done_o     (done_o)
    );

endmodule

//--- verif/gemm_checker.sv
// ----------------------------------------------------------------------
// gemm accelerator checker
// watches the memory ports and done, compares against expected values
// ----------------------------------------------------------------------
`timescale 1ns/100ps
`include "gemm_defines.svh"

module gemm_checker (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                start_i,
    input  gemm_pkg::mat_cfg_t  cfg_i,
    input  gemm_pkg::acc_tile_t exp_tile_i,
    input  logic                rd_req_valid_i,
    input  logic [`GEMM_AW-1:0] rd_req_addr_i,
    input  logic                rd_req_ready_i,
    input  logic                wr_valid_i,
    input  gemm_pkg::mem_wr_t   wr_i,
    input  logic                wr_ready_i,
    input  logic                done_i,
    output int                  err_cnt_o
);
    import gemm_pkg::*;

    localparam int DIM   = `GEMM_DIM;
    localparam int ROWS  = 2 * `GEMM_DIM;
    localparam int BEATS = `GEMM_DIM * `GEMM_DIM;

    mat_cfg_t  cfg_q;
    acc_tile_t exp_q;
    int        rd_cnt;
    int        wr_cnt;
    // between done and the next start
    logic      idle_q;
    logic      last_beat_q;
    // beat stalled last cycle and its value
    logic      hold_q;
    mem_wr_t   held_wr_q;

    always @(posedge clk) begin
        logic [`GEMM_AW-1:0]    exp_addr;
        logic [`GEMM_ACC_W-1:0] exp_data;
        if (!rst_n) begin
            err_cnt_o = 0;
            rd_cnt      <= 0;
            wr_cnt      <= 0;
            idle_q      <= 1'b1;
            last_beat_q <= 1'b0;
            hold_q      <= 1'b0;
        end else begin
            if (start_i) begin
                cfg_q  <= cfg_i;
                exp_q  <= exp_tile_i;
                rd_cnt <= 0;
                wr_cnt <= 0;
                idle_q <= 1'b0;
            end
            if (idle_q && (rd_req_valid_i || wr_valid_i)) begin
                $display("memory traffic seen between done_o and the next start");
                err_cnt_o++;
            end
            // A rows first, then B rows, four bytes apart
            if (rd_req_valid_i && rd_req_ready_i) begin
                if (rd_cnt >= ROWS) begin
                    $display("more than %0d read requests in one run", ROWS);
                    err_cnt_o++;
                end else begin
                    exp_addr = (rd_cnt < DIM) ? cfg_q.a_addr : cfg_q.b_addr;
                    exp_addr = exp_addr + 4 * (rd_cnt % DIM);
                    if (rd_req_addr_i !== exp_addr) begin
                        $display("ERROR rd_req_addr_o: expected %h, actual %h",
                                 exp_addr, rd_req_addr_i);
                        err_cnt_o++;
                    end
                end
                rd_cnt <= rd_cnt + 1;
            end
            // beat n is C[n/4][n%4] at c_addr + 4n
            if (wr_valid_i && wr_ready_i) begin
                if (wr_cnt >= BEATS) begin
                    $display("more than %0d writes in one run", BEATS);
                    err_cnt_o++;
                end else begin
                    exp_addr = cfg_q.c_addr + 4 * wr_cnt;
                    exp_data = exp_q[wr_cnt / DIM][wr_cnt % DIM];
                    if (wr_i.addr !== exp_addr) begin
                        $display("ERROR wr_o.addr: expected %h, actual %h", exp_addr, wr_i.addr);
                        err_cnt_o++;
                    end
                    if (wr_i.data !== exp_data) begin
                        $display("ERROR wr_o.data: expected %h, actual %h", exp_data, wr_i.data);
                        err_cnt_o++;
                    end
                end
                wr_cnt <= wr_cnt + 1;
            end
            last_beat_q <= wr_valid_i && wr_ready_i && (wr_cnt == BEATS - 1);
            // done exactly one cycle after the last accepted beat
            if (done_i !== last_beat_q) begin
                if (done_i) begin
                    $display("done_o raised without a final write just before it");
                end else begin
                    $display("done_o missing one cycle after the last write");
                end
                err_cnt_o++;
            end
            if (done_i) begin
                idle_q <= 1'b1;
            end
            // stalled beat must hold
            if (hold_q) begin
                if (!wr_valid_i) begin
                    $display("wr_valid_o dropped before the beat was accepted");
                    err_cnt_o++;
                end else if (wr_i !== held_wr_q) begin
                    $display("ERROR wr_o: expected %h, actual %h", held_wr_q, wr_i);
                    err_cnt_o++;
                end
            end
            hold_q    <= wr_valid_i && !wr_ready_i;
            held_wr_q <= wr_i;
        end
    end

endmodule

//--- verif/tb_gemm.sv
// ----------------------------------------------------------------------
// gemm accelerator testbench
// memory model with random ready and latency, tests read from a file
// ----------------------------------------------------------------------
`timescale 1ns/100ps
`include "gemm_defines.svh"

module tb_gemm;
    import gemm_pkg::*;

    // words per test: three addresses, then A, B and expected C
    localparam int N2         = `GEMM_DIM * `GEMM_DIM;
    localparam int TEST_WORDS = 3 + 3 * N2;
    localparam int MAX_TESTS  = 16;

    logic                clk;
    logic                rst_n;
    logic                start;
    mat_cfg_t            cfg;
    logic                rd_req_valid;
    logic [`GEMM_AW-1:0] rd_req_addr;
    logic                rd_req_ready;
    logic                rd_rsp_valid;
    row_t                rd_rsp_data;
    logic                wr_valid;
    mem_wr_t             wr;
    logic                wr_ready;
    logic                done;
    acc_tile_t           exp_tile;
    int                  chk_errs;
    int                  tb_errs;
    int                  num_tests;
    int                  cycle_cnt = 0;
    int                  timeout_limit;

    logic [31:0]         tv [MAX_TESTS * TEST_WORDS];
    // read memory, one row per word address
    row_t                mem_rows [logic [`GEMM_AW-1:0]];
    // accepted reads waiting for their response
    logic [`GEMM_AW-1:0] pend_addr_q [$];
    int                  pend_due_q [$];

    gemm_accel_top DUT (
        .clk            (clk),
        .rst_n          (rst_n),
        .start_i        (start),
        .cfg_i          (cfg),
        .rd_req_valid_o (rd_req_valid),
        .rd_req_addr_o  (rd_req_addr),
        .rd_req_ready_i (rd_req_ready),
        .rd_rsp_valid_i (rd_rsp_valid),
        .rd_rsp_data_i  (rd_rsp_data),
        .wr_valid_o     (wr_valid),
        .wr_o           (wr),
        .wr_ready_i     (wr_ready),
        .done_o         (done)
    );

    gemm_checker u_checker (
        .clk            (clk),
        .rst_n          (rst_n),
        .start_i        (start),
        .cfg_i          (cfg),
        .exp_tile_i     (exp_tile),
        .rd_req_valid_i (rd_req_valid),
        .rd_req_addr_i  (rd_req_addr),
        .rd_req_ready_i (rd_req_ready),
        .wr_valid_i     (wr_valid),
        .wr_i           (wr),
        .wr_ready_i     (wr_ready),
        .done_i         (done),
        .err_cnt_o      (chk_errs)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    // one file row packed into a memory word, element k in byte k
    function automatic row_t file_row(input int idx);
        row_t r;
        for (int k = 0; k < `GEMM_DIM; k++) begin
            r[k] = tv[idx + k][`GEMM_EW-1:0];
        end
        return r;
    endfunction

    // unknown addresses return a pattern made from the address
    function automatic row_t read_row(input logic [`GEMM_AW-1:0] addr);
        if (mem_rows.exists(addr)) begin
            return mem_rows[addr];
        end
        return row_t'(~addr);
    endfunction

    // memory model, in-order responses 1 to 6 cycles after acceptance
    initial begin
        void'($urandom(60));
        forever begin
            @(posedge clk);
            if (!rst_n) begin
                rd_req_ready <= 1'b0;
                wr_ready     <= 1'b0;
                rd_rsp_valid <= 1'b0;
            end else begin
                rd_req_ready <= ($urandom % 4) != 0;
                wr_ready     <= ($urandom % 3) != 0;
                if (rd_req_valid && rd_req_ready) begin
                    pend_addr_q.push_back(rd_req_addr);
                    pend_due_q.push_back(cycle_cnt + 1 + int'($urandom % 6));
                end
                rd_rsp_valid <= 1'b0;
                // only the oldest read may answer
                if (pend_due_q.size() > 0 && pend_due_q[0] <= cycle_cnt) begin
                    rd_rsp_valid <= 1'b1;
                    rd_rsp_data  <= read_row(pend_addr_q.pop_front());
                    void'(pend_due_q.pop_front());
                end
            end
        end
    end

    task automatic run_test(input int t);
        int base;
        base = t * TEST_WORDS;
        mem_rows.delete();
        for (int r = 0; r < `GEMM_DIM; r++) begin
            mem_rows[tv[base] + 4 * r]     = file_row(base + 3 + `GEMM_DIM * r);
            mem_rows[tv[base + 1] + 4 * r] = file_row(base + 3 + N2 + `GEMM_DIM * r);
        end
        for (int n = 0; n < N2; n++) begin
            exp_tile[n / `GEMM_DIM][n % `GEMM_DIM] = tv[base + 3 + 2 * N2 + n];
        end
        @(posedge clk);
        start        <= 1'b1;
        cfg.a_addr   <= tv[base];
        cfg.b_addr   <= tv[base + 1];
        cfg.c_addr   <= tv[base + 2];
        @(posedge clk);
        start <= 1'b0;
        // run length varies, done_o ends it
        do begin
            @(posedge clk);
        end while (!done);
    endtask

    initial begin
        rst_n         = 1'b0;
        start         = 1'b0;
        cfg           = '0;
        rd_req_ready  = 1'b0;
        rd_rsp_valid  = 1'b0;
        rd_rsp_data   = '0;
        wr_ready      = 1'b0;
        exp_tile      = '0;
        tb_errs       = 0;
        num_tests     = 0;
        timeout_limit = 0;
        $readmemh("verif/gemm_tests.txt", tv);
        while (num_tests < MAX_TESTS && tv[num_tests * TEST_WORDS] !== 'x) begin
            num_tests++;
        end
        timeout_limit = num_tests * 200;
        if (num_tests == 0) begin
            $display("no tests found in the test file");
            tb_errs++;
        end
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        repeat (2) @(posedge clk);
        // back to back, no reset in between
        for (int t = 0; t < num_tests; t++) begin
            run_test(t);
        end
        repeat (4) @(posedge clk);
        $display("%0d errors over %0d tests", chk_errs + tb_errs, num_tests);
        if (chk_errs + tb_errs == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    // run limit scales with the number of tests
    initial begin
        wait (timeout_limit > 0);
        while (cycle_cnt < timeout_limit) begin
            @(posedge clk);
        end
        $display("run timed out after %0d cycles", cycle_cnt);
        $display("Checks failed");
        $finish;
    end

endmodule

//--- verif/gemm_tests.txt
// per test, all hex: a_addr b_addr c_addr / A[0][0]..A[3][3] / B[0][0]..B[3][3]
// then the sixteen expected 32-bit words C[0][0]..C[3][3], row-major
00001000 00001040 00002000
01 02 03 04 fb 06 f9 08 10 20 30 40 80 7f ff 00
01 00 00 00 00 01 00 00 00 00 01 00 00 00 00 01
00000001 00000002 00000003 00000004 fffffffb 00000006 fffffff9 00000008 00000010 00000020 00000030 00000040 ffffff80 0000007f ffffffff 00000000
00010000 00010100 00020000
80 80 80 80 80 80 80 80 7f 7f 7f 7f 7f 7f 7f 7f
80 7f 80 7f 80 7f 80 80 80 7f 7f 7f 80 7f 7f 80
00010000 ffff0200 00000100 00000100 00010000 ffff0200 00000100 00000100 ffff0200 0000fc04 ffffff02 ffffff02 ffff0200 0000fc04 ffffff02 ffffff02
80000000 80000010 80000020
02 ff 03 00 fe 04 01 05 07 00 fd 02 01 01 01 01
03 01 fc 02 00 fe 05 01 ff 06 02 fd 04 03 00 ff
00000003 00000016 fffffff9 fffffffa 0000000d 0000000b 0000001e fffffff8 00000020 fffffffb ffffffde 00000015 00000006 00000008 00000003 ffffffff
0000fff0 00000000 00003000
7f 7f 7f 7f 80 80 80 80 64 9c 64 9c 00 00 00 00
7f 80 01 ff 7f 80 01 ff 7f 7f 02 00 80 7f 02 00
00007d83 ffffff02 000002fa ffffff02 ffff8180 00000100 fffffd00 00000100 0000639c 00000000 00000000 00000000 00000000 00000000 00000000 00000000

//--- compile.f
+incdir+verilog
verilog/gemm_pkg.sv
verilog/tile_buffer.sv
verilog/dma_fetch.sv
verilog/mm_engine.sv
verilog/dma_writeback.sv
verilog/gemm_accel_top.sv
verif/gemm_checker.sv
verif/tb_gemm.sv
